/* tests/axi_rd_testdata.txt */
# A lines hold id addr len size burst in hex and then an idle gap in cycles
# B lines hold the expected data resp last of each R beat in acceptance order
A 1 0010 0 2 1 4
B 00010010 0 1
A 2 0101 2 0 1 2
B 00020101 0 0
B 00020102 0 0
B 00020103 0 1
A 3 0201 1 1 1 2
B 00030201 0 0
B 00030202 0 1
A 4 0303 2 2 1 2
B 00040303 0 0
B 00040304 0 0
B 00040308 0 1
A 5 0408 3 2 2 2
B 00050408 0 0
B 0005040c 0 0
B 00050400 0 0
B 00050404 0 1
A 6 0500 2 2 0 2
B 00060500 0 0
B 00060500 0 0
B 00060500 0 1
A f 0600 1 2 1 6
B 000f0600 0 0
B 000f0604 2 1
A 7 0700 1 2 1 0
B 00070700 0 0
B 00070704 0 1
A 8 0810 0 2 1 0
B 00080810 0 1
A 9 0901 1 0 1 0
B 00090901 0 0
B 00090902 0 1
A a 0a04 1 2 2 0
B 000a0a04 0 0
B 000a0a00 0 1
A b 0b02 0 1 0 0
B 000b0b02 0 1

/* project.f */
common/axi_rd_pkg.sv
ost/burst_addr_step.sv
ost/ost_entry.sv
ost/ost_alloc.sv
verilog/r_channel_mux.sv
verilog/axi_rd_slave.sv
tests/axi_rd_props.sv
tests/tb_axi_rd_slave.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build with Verilator, run from the project root, then scan sim.log
rm -f sim.log
verilator --binary --timing --assert -f project.f --top-module tb_axi_rd_slave \
    -o tb_axi_rd_slave \
    && { ./obj_dir/tb_axi_rd_slave 2>&1 | tee sim.log; } \
    && ! grep -q "Some tests failed" sim.log \
    && grep -q "All tests passed" sim.log \
    && echo "Simulation PASSED" \
    || { echo "Simulation FAILED, see sim.log"; exit 1; }

/* tests/tb_axi_rd_slave.sv */
// Testbench for the AXI read-only slave, stimulus and expected beats from a data file
// Run from the project root so the data file path resolves
// rready follows an LFSR, so back-pressure is random but repeatable
module tb_axi_rd_slave;
    import axi_rd_pkg::*;

    localparam int CLK_PERIOD  = 4;
    localparam int DRIVE_DELAY = 1;
    localparam int RESET_CYCLES = 3;
    localparam logic [15:0] LFSR_SEED = 16'd9;

    logic                  clk;
    logic                  rst_n;
    logic                  arvalid;
    logic                  arready;
    ar_req_t               ar;
    logic                  rvalid;
    logic                  rready;
    logic [ID_W-1:0]       rid;
    r_data_u               rdata;
    logic [RESP_W-1:0]     rresp;
    logic                  rlast;

    ar_req_t               req_q [$];
    int                    gap_q [$];
    r_beat_t               exp_q [$];
    logic [15:0]           lfsr;
    int                    n_req;
    int                    stall_cycles;
    int                    data_errs;
    int                    id_errs;
    int                    resp_errs;
    int                    last_errs;
    int                    assert_errs;
    int                    other_errs;

    axi_rd_slave i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .arvalid (arvalid),
        .arready (arready),
        .ar      (ar),
        .rvalid  (rvalid),
        .rready  (rready),
        .rid     (rid),
        .rdata   (rdata),
        .rresp   (rresp),
        .rlast   (rlast)
    );

    bind axi_rd_slave axi_rd_props i_props (
        .clk     (clk),
        .rst_n   (rst_n),
        .arready (arready),
        .rvalid  (rvalid),
        .rready  (rready),
        .rid     (rid),
        .rdata   (rdata),
        .rresp   (rresp),
        .rlast   (rlast)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic load_testdata();
        int          fd;
        int          n;
        int          gap;
        string       line;
        logic [31:0] f0;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;
        ar_req_t     req;
        r_beat_t     beat;
        fd = $fopen("tests/axi_rd_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test data file");
            other_errs++;
            return;
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && line.substr(0, 0) == "A") begin
                n = $sscanf(line, "A %h %h %h %h %h %d", f0, f1, f2, f3, f4, gap);
                req.id    = f0[ID_W-1:0];
                req.addr  = f1[ADDR_W-1:0];
                req.len   = f2[LEN_W-1:0];
                req.size  = f3[SIZE_W-1:0];
                req.burst = f4[BURST_W-1:0];
                req_q.push_back(req);
                gap_q.push_back(gap);
            end else if (n > 0 && line.substr(0, 0) == "B") begin
                n = $sscanf(line, "B %h %h %h", f0, f1, f2);
                beat.data.raw = f0;
                beat.resp     = f1[RESP_W-1:0];
                beat.last     = f2[0];
                exp_q.push_back(beat);
            end
        end
        $fclose(fd);
    endtask

    task automatic check_data(input r_data_u got, input r_data_u want);
        if (got !== want) begin
            $display("mismatch at %0t: rdata got %h expected %h", $time, got.raw, want.raw);
            data_errs++;
        end
    endtask

    task automatic check_id(input logic [ID_W-1:0] got, input logic [ID_W-1:0] want);
        if (got !== want) begin
            $display("mismatch at %0t: rid got %h expected %h", $time, got, want);
            id_errs++;
        end
    endtask

    task automatic check_resp(input logic [RESP_W-1:0] got, input logic [RESP_W-1:0] want);
        if (got !== want) begin
            $display("mismatch at %0t: rresp got %0d expected %0d", $time, got, want);
            resp_errs++;
        end
    endtask

    task automatic check_last(input logic got, input logic want);
        if (got !== want) begin
            $display("mismatch at %0t: rlast got %0b expected %0b", $time, got, want);
            last_errs++;
        end
    endtask

    // ----------------------------------------
    // AR driver and R checker
    // ----------------------------------------
    task automatic drive_requests();
        logic accepted;
        @(posedge clk);
        #DRIVE_DELAY;
        foreach (req_q[i]) begin
            arvalid = 1'b1;
            ar      = req_q[i];
            // Sample mid-cycle, the handshake lands on the next edge
            do begin
                @(negedge clk);
                accepted = arready;
                if (!accepted) begin
                    stall_cycles++;
                end
            end while (!accepted);
            @(posedge clk);
            #DRIVE_DELAY;
            arvalid = 1'b0;
            repeat (gap_q[i]) begin
                @(posedge clk);
                #DRIVE_DELAY;
            end
        end
    endtask

    task automatic drain_beats();
        r_beat_t want;
        while (exp_q.size() > 0) begin
            @(posedge clk);
            #DRIVE_DELAY;
            lfsr   = lfsr_step(lfsr);
            rready = lfsr[0];
            @(negedge clk);
            if (rvalid && rready) begin
                want = exp_q.pop_front();
                check_data(rdata, want.data);
                check_id(rid, want.data.fields.id);
                check_resp(rresp, want.resp);
                check_last(rlast, want.last);
            end
        end
        @(posedge clk);
        #DRIVE_DELAY;
        rready = 1'b0;
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        rst_n        = 1'b0;
        arvalid      = 1'b0;
        ar           = '0;
        rready       = 1'b0;
        lfsr         = LFSR_SEED;
        stall_cycles = 0;
        data_errs    = 0;
        id_errs      = 0;
        resp_errs    = 0;
        last_errs    = 0;
        assert_errs  = 0;
        other_errs   = 0;
        n_req        = 0;
        load_testdata();
        n_req = req_q.size();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        @(negedge clk);
        if (arready !== 1'b1 || rvalid !== 1'b0 || rlast !== 1'b0) begin
            $display("After reset arready is not high or rvalid/rlast is not low");
            other_errs++;
        end
        fork
            drive_requests();
            drain_beats();
        join
        // Five back-to-back requests must have found all slots taken
        if (stall_cycles == 0) begin
            $display("arready never dropped although all slots were in use");
            other_errs++;
        end
        assert_errs = i_dut.i_props.hold_fails + i_dut.i_props.last_fails
                      + i_dut.i_props.ready_fails;
        $display("Errors: data %0d, id %0d, resp %0d, last %0d, assert %0d, other %0d",
                 data_errs, id_errs, resp_errs, last_errs, assert_errs, other_errs);
        if (data_errs + id_errs + resp_errs + last_errs + assert_errs + other_errs == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Watchdog, 9 beats of 20 cycles per request
    initial begin
        wait (n_req > 0);
        #(n_req * 9 * 20 * CLK_PERIOD);
        $display("Timeout before all expected R beats arrived");
        $display("Some tests failed");
        $finish;
    end

endmodule

/* tests/axi_rd_props.sv */
// Concurrent checks on the AR and R handshakes
// Attached to the DUT by bind, checks are off during reset
module axi_rd_props (
    input logic                              clk,
    input logic                              rst_n,
    input logic                              arready,
    input logic                              rvalid,
    input logic                              rready,
    input logic [axi_rd_pkg::ID_W-1:0]       rid,
    input axi_rd_pkg::r_data_u               rdata,
    input logic [axi_rd_pkg::RESP_W-1:0]     rresp,
    input logic                              rlast
);

    // Failure counts per property
    int hold_fails  = 0;
    int last_fails  = 0;
    int ready_fails = 0;

    // R fields held while the master stalls
    r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rid) && $stable(rdata.raw)
                              && $stable(rresp) && $stable(rlast))
        else begin
            $error("R channel changed while rvalid was high and rready low");
            hold_fails++;
        end

    r_last_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
        rlast |-> rvalid)
        else begin
            $error("rlast high without rvalid");
            last_fails++;
        end

    // A retired burst frees its slot in the next cycle
    ar_ready_after_retire: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && rready && rlast |=> arready)
        else begin
            $error("arready low in the cycle after a burst retired");
            ready_fails++;
        end

endmodule

/* verilog/axi_rd_slave.sv */
// AXI read-only slave with OST_DEPTH bursts in flight
// Bursts return in acceptance order, no interleaving across IDs
// No write channels
module axi_rd_slave (
    input  logic                                clk,
    input  logic                                rst_n,
    // AR channel
    input  logic                                arvalid,
    output logic                                arready,
    input  axi_rd_pkg::ar_req_t                 ar,
    // R channel
    output logic                                rvalid,
    input  logic                                rready,
    output logic [axi_rd_pkg::ID_W-1:0]         rid,
    output axi_rd_pkg::r_data_u                 rdata,
    output logic [axi_rd_pkg::RESP_W-1:0]       rresp,
    output logic                                rlast
);
    import axi_rd_pkg::*;

    logic [OST_DEPTH-1:0]            busy;
    logic [OST_DEPTH-1:0]            alloc_sel;
    logic [OST_DEPTH-1:0]            pop_sel;
    logic [OST_DEPTH-1:0]            beat_valid;
    r_beat_t [OST_DEPTH-1:0]         head_beats;
    logic [SLOT_W-1:0]               head_slot;
    logic                            retire;

    // ----------------------------------------
    // Slot allocation and return order
    // ----------------------------------------
    ost_alloc i_alloc (
        .clk       (clk),
        .rst_n     (rst_n),
        .arvalid   (arvalid),
        .arready   (arready),
        .busy      (busy),
        .retire    (retire),
        .alloc_sel (alloc_sel),
        .head_slot (head_slot)
    );

    // One entry per outstanding slot
    for (genvar g = 0; g < OST_DEPTH; g++) begin : g_slot
        ost_entry i_entry (
            .clk        (clk),
            .rst_n      (rst_n),
            .alloc      (alloc_sel[g]),
            .ar         (ar),
            .pop        (pop_sel[g]),
            .busy       (busy[g]),
            .head_beat  (head_beats[g]),
            .beat_valid (beat_valid[g])
        );
    end

    // ----------------------------------------
    // R channel
    // ----------------------------------------
    r_channel_mux i_r_mux (
        .head_slot  (head_slot),
        .head_beats (head_beats),
        .beat_valid (beat_valid),
        .rvalid     (rvalid),
        .rready     (rready),
        .rid        (rid),
        .rdata      (rdata),
        .rresp      (rresp),
        .rlast      (rlast),
        .pop_sel    (pop_sel),
        .retire     (retire)
    );

endmodule

/* verilog/r_channel_mux.sv */
// R channel driver from the slot at the head of the order queue
// Purely combinational, R fields follow the held head beat
module r_channel_mux (
    input  logic [axi_rd_pkg::SLOT_W-1:0]                  head_slot,
    input  axi_rd_pkg::r_beat_t [axi_rd_pkg::OST_DEPTH-1:0] head_beats,
    input  logic [axi_rd_pkg::OST_DEPTH-1:0]               beat_valid,
    output logic                                           rvalid,
    input  logic                                           rready,
    output logic [axi_rd_pkg::ID_W-1:0]                    rid,
    output axi_rd_pkg::r_data_u                            rdata,
    output logic [axi_rd_pkg::RESP_W-1:0]                  rresp,
    output logic                                           rlast,
    output logic [axi_rd_pkg::OST_DEPTH-1:0]               pop_sel,
    output logic                                           retire
);
    import axi_rd_pkg::*;

    r_beat_t sel_beat;
    logic    r_hs;

    assign sel_beat = head_beats[head_slot];
    assign rvalid   = beat_valid[head_slot];
    assign r_hs     = rvalid & rready;

    // ----------------------------------------
    // R fields
    // ----------------------------------------
    assign rdata = sel_beat.data;
    assign rid   = sel_beat.data.fields.id;
    assign rresp = sel_beat.resp;
    assign rlast = rvalid & sel_beat.last;

    // Beat taken, and slot retired on its last beat
    assign pop_sel = r_hs ? (OST_DEPTH'(1) << head_slot) : '0;
    assign retire  = r_hs & sel_beat.last;

endmodule

/* ost/ost_alloc.sv */
// Slot allocator and order queue
// The queue never overflows, since a slot is pushed only while one is free
// head_slot is stale while no burst is outstanding
module ost_alloc (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   arvalid,
    output logic                                   arready,
    input  logic [axi_rd_pkg::OST_DEPTH-1:0]       busy,
    input  logic                                   retire,
    output logic [axi_rd_pkg::OST_DEPTH-1:0]       alloc_sel,
    output logic [axi_rd_pkg::SLOT_W-1:0]          head_slot
);
    import axi_rd_pkg::*;

    logic [SLOT_W-1:0] free_slot;
    logic              ar_hs;
    logic [SLOT_W-1:0] order_q [OST_DEPTH];
    logic [SLOT_W-1:0] wr_ptr;
    logic [SLOT_W-1:0] rd_ptr;

    // ----------------------------------------
    // Lowest free slot
    // ----------------------------------------
    always_comb begin
        free_slot = '0;
        // Scan downwards so the lowest free index wins
        for (int i = OST_DEPTH - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                free_slot = SLOT_W'(i);
            end
        end
    end

    assign arready   = ~&busy;
    assign ar_hs     = arvalid & arready;
    assign alloc_sel = ar_hs ? (OST_DEPTH'(1) << free_slot) : '0;

    // ----------------------------------------
    // Order queue of slot numbers
    // ----------------------------------------
    // Pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            order_q <= '{default: '0};
        end else begin
            if (ar_hs) begin
                order_q[wr_ptr] <= free_slot;
                wr_ptr          <= wr_ptr + 1'b1;
            end
            if (retire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    assign head_slot = order_q[rd_ptr];

endmodule

/* ost/ost_entry.sv */
// One outstanding read slot with its own beat buffer
// Fetch delay per beat is FETCH_DELAY minus the request ID
// Assumes ARLEN <= 7 so the whole burst fits in the buffer
module ost_entry (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 alloc,
    input  axi_rd_pkg::ar_req_t  ar,
    input  logic                 pop,
    output logic                 busy,
    output axi_rd_pkg::r_beat_t  head_beat,
    output logic                 beat_valid
);
    import axi_rd_pkg::*;

    ar_req_t                 req;
    logic [ADDR_W-1:0]       cur_addr;
    logic [ADDR_W-1:0]       next_addr;
    logic [FETCH_CNT_W-1:0]  fetch_cnt;
    logic [FETCH_CNT_W-1:0]  fetch_target;
    logic                    fetch_done;
    logic [BEAT_W-1:0]       wr_idx;
    logic [BEAT_W-1:0]       rd_idx;
    logic                    wr_last;
    logic [MAX_BEATS-1:0]    beat_vld;
    r_beat_t                 beat_buf [MAX_BEATS];
    r_beat_t                 new_beat;

    // ----------------------------------------
    // Address generation
    // ----------------------------------------
    burst_addr_step i_step (
        .cur_addr  (cur_addr),
        .req       (req),
        .next_addr (next_addr)
    );

    // Request and current address
    always_ff @(posedge clk) begin
        if (alloc) begin
            req      <= ar;
            cur_addr <= ar.addr;
        end else if (fetch_done) begin
            cur_addr <= next_addr;
        end
    end

    // ----------------------------------------
    // Fetch model
    // ----------------------------------------
    assign fetch_target = FETCH_CNT_W'(FETCH_DELAY) - FETCH_CNT_W'(req.id);
    assign fetch_done   = busy & (fetch_cnt == fetch_target);
    assign wr_last      = (wr_idx == req.len[BEAT_W-1:0]);

    // Beat contents, SLVERR only on the last beat of ID all-ones
    always_comb begin
        new_beat                  = '0;
        new_beat.data.fields.id   = req.id;
        new_beat.data.fields.addr = cur_addr;
        new_beat.last             = wr_last;
        if (wr_last && (req.id == {ID_W{1'b1}})) begin
            new_beat.resp = RESP_SLVERR;
        end else begin
            new_beat.resp = RESP_OKAY;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_done) begin
            beat_buf[wr_idx] <= new_beat;
        end
    end

    // Timer runs from 1, zero means idle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_cnt <= '0;
        end else if (alloc) begin
            fetch_cnt <= FETCH_CNT_W'(1);
        end else if (fetch_done) begin
            fetch_cnt <= wr_last ? '0 : FETCH_CNT_W'(1);
        end else if (fetch_cnt != '0) begin
            fetch_cnt <= fetch_cnt + 1'b1;
        end
    end

    // ----------------------------------------
    // Slot state and read side
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            wr_idx   <= '0;
            rd_idx   <= '0;
            beat_vld <= '0;
        end else if (alloc) begin
            busy     <= 1'b1;
            wr_idx   <= '0;
            rd_idx   <= '0;
            beat_vld <= '0;
        end else begin
            if (fetch_done) begin
                beat_vld[wr_idx] <= 1'b1;
                wr_idx           <= wr_idx + 1'b1;
            end
            if (pop) begin
                rd_idx <= rd_idx + 1'b1;
                // Slot frees with the last beat taken
                if (head_beat.last) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    assign head_beat  = beat_buf[rd_idx];
    assign beat_valid = busy & beat_vld[rd_idx];

endmodule

/* ost/burst_addr_step.sv */
// Next beat address for FIXED, INCR and WRAP bursts
// WRAP assumes len+1 is 2, 4 or 8, so the block size is a power of two
module burst_addr_step (
    input  logic [axi_rd_pkg::ADDR_W-1:0]  cur_addr,
    input  axi_rd_pkg::ar_req_t            req,
    output logic [axi_rd_pkg::ADDR_W-1:0]  next_addr
);
    import axi_rd_pkg::*;

    logic [ADDR_W-1:0] num_bytes;
    logic [ADDR_W-1:0] aligned;
    logic [ADDR_W-1:0] stepped;
    logic [ADDR_W-1:0] wrap_mask;
    logic [ADDR_W-1:0] boundary;

    always_comb begin
        num_bytes = ADDR_W'(1) << req.size;
        aligned   = cur_addr & ~(num_bytes - 1'b1);
        stepped   = aligned + num_bytes;
        // Block of (len+1) beats
        wrap_mask = ((ADDR_W'(req.len) + 1'b1) << req.size) - 1'b1;
        boundary  = cur_addr & ~wrap_mask;

        case (req.burst)
            BURST_FIXED: next_addr = cur_addr;
            BURST_INCR:  next_addr = stepped;
            // Carry out of the block drops, which lands back on the boundary
            BURST_WRAP:  next_addr = boundary | (stepped & wrap_mask);
            default:     next_addr = cur_addr;
        endcase
    end

endmodule

/* common/axi_rd_pkg.sv */
// Shared widths, codes and types for the AXI read-only slave
// Requests are limited to ARLEN <= 7 and ARSIZE <= 2
// WRAP bursts must use lengths of 2, 4 or 8 beats
package axi_rd_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int ID_W    = 4;
    localparam int ADDR_W  = 16;
    localparam int DATA_W  = 32;
    localparam int LEN_W   = 8;
    localparam int SIZE_W  = 3;
    localparam int BURST_W = 2;
    localparam int RESP_W  = 2;

    // Burst and response codes
    localparam logic [BURST_W-1:0] BURST_FIXED = 2'd0;
    localparam logic [BURST_W-1:0] BURST_INCR  = 2'd1;
    localparam logic [BURST_W-1:0] BURST_WRAP  = 2'd2;
    localparam logic [RESP_W-1:0]  RESP_OKAY   = 2'd0;
    localparam logic [RESP_W-1:0]  RESP_SLVERR = 2'd2;

    // ----------------------------------------
    // Depths and delays
    // ----------------------------------------
    localparam int OST_DEPTH   = 4;
    localparam int SLOT_W      = 2;
    localparam int MAX_BEATS   = 8;
    localparam int BEAT_W      = 3;
    localparam int FETCH_DELAY = 18;
    localparam int FETCH_CNT_W = 5;

    // One AR request
    typedef struct packed {
        logic [ID_W-1:0]    id;
        logic [ADDR_W-1:0]  addr;
        logic [LEN_W-1:0]   len;
        logic [SIZE_W-1:0]  size;
        logic [BURST_W-1:0] burst;
    } ar_req_t;

    // Data word layout, id and address with zero padding on top
    typedef struct packed {
        logic [DATA_W-ID_W-ADDR_W-1:0] pad;
        logic [ID_W-1:0]               id;
        logic [ADDR_W-1:0]             addr;
    } r_fields_t;

    typedef union packed {
        logic [DATA_W-1:0] raw;
        r_fields_t         fields;
    } r_data_u;

    // One buffered beat
    typedef struct packed {
        r_data_u           data;
        logic [RESP_W-1:0] resp;
        logic              last;
    } r_beat_t;

endpackage
